//--- Makefile
TOP = tb_genesis_bus

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- hw/byte_lane_ram.sv
// ------------------------------------------------
// Single-port synchronous RAM
// Registered read, one write enable per byte lane
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module byte_lane_ram #(
	parameter int ADDR_W = 15,
	parameter int LANES  = 2
) (
	input  wire                  MCLK,
	input  wire  [ADDR_W-1:0]    addr,
	input  wire  [8*LANES-1:0]   wdata,
	input  wire  [LANES-1:0]     we,
	output logic [8*LANES-1:0]   rdata
);

	logic [8*LANES-1:0] mem [0:(1<<ADDR_W)-1];

	// Read returns the old word during a write
	always_ff @(posedge MCLK) begin
		for (int i = 0; i < LANES; i++) begin
			if (we[i]) begin
				mem[addr][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

//--- hw/genesis_bus_pkg.sv
// ------------------------------------------------
// Genesis bus fabric shared definitions
// Bus widths, address map and open-bus values
// ------------------------------------------------
`default_nettype none

package genesis_bus_pkg;

	// ------------------------------------------------
	// Widths
	// ------------------------------------------------
	// Main bus carries word addresses 23:1
	localparam int M68K_AW = 23;
	localparam int M68K_DW = 16;
	localparam int Z80_AW  = 16;
	localparam int Z80_DW  = 8;
	localparam int ZBUS_AW = 15;
	localparam int BANK_W  = 9;

	// ------------------------------------------------
	// Main-bus address map
	// ------------------------------------------------
	// Region code in bits 23:21
	localparam logic [2:0]  WRAM_TOP        = 3'b111;
	// Z80 window page in bits 23:16
	localparam logic [7:0]  ZWIN_PAGE       = 8'hA0;
	localparam logic [11:0] CTRL_PAGE       = 12'hA11;
	localparam logic [3:0]  CTRL_BUSREQ_SEL = 4'h1;
	localparam logic [3:0]  CTRL_RESET_SEL  = 4'h2;
	localparam int          CTRL_BIT        = 8;

	// Z80 local pages in bits 14:8
	localparam logic [6:0]  Z80_BANK_PAGE   = 7'h60;
	localparam logic [6:0]  Z80_LOCAL_LIMIT = 7'h7F;

	// Open bus reads as all ones
	localparam logic [15:0] OPEN_WORD = 16'hFFFF;
	localparam logic [7:0]  OPEN_BYTE = 8'hFF;

endpackage

`default_nettype wire

//--- hw/genesis_bus_top.sv
// ------------------------------------------------
// Genesis main bus fabric
// 68000 and Z80 APB ports, main-bus and Z80-bus
// controllers and the 64 KB work RAM
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module genesis_bus_top #(
	parameter int WRAM_AW = 15,
	parameter int ZRAM_AW = 13
) (
	input  wire                                 MCLK,
	input  wire                                 reset,
	// 68000 side
	input  wire                                 m68k_psel,
	input  wire                                 m68k_penable,
	input  wire                                 m68k_pwrite,
	input  wire  [genesis_bus_pkg::M68K_AW:0]   m68k_paddr,
	input  wire  [genesis_bus_pkg::M68K_DW-1:0] m68k_pwdata,
	input  wire  [1:0]                          m68k_pstrb,
	output wire  [genesis_bus_pkg::M68K_DW-1:0] m68k_prdata,
	output wire                                 m68k_pready,
	// Z80 side
	input  wire                                 z80_psel,
	input  wire                                 z80_penable,
	input  wire                                 z80_pwrite,
	input  wire  [genesis_bus_pkg::Z80_AW-1:0]  z80_paddr,
	input  wire  [genesis_bus_pkg::Z80_DW-1:0]  z80_pwdata,
	output wire  [genesis_bus_pkg::Z80_DW-1:0]  z80_prdata,
	output wire                                 z80_pready,
	output wire                                 z80_busreq_n,
	output wire                                 z80_reset_n
);

	mbus_if mb_m68k ();
	mbus_if mb_z80 ();
	zbus_if zb_main ();
	zbus_if zb_z80 ();

	wire [WRAM_AW-1:0]                  wram_addr;
	wire [genesis_bus_pkg::M68K_DW-1:0] wram_wdata;
	wire [1:0]                          wram_we;
	wire [genesis_bus_pkg::M68K_DW-1:0] wram_rdata;

	m68k_apb_port m68k_port (
		.MCLK    (MCLK),
		.reset   (reset),
		.psel    (m68k_psel),
		.penable (m68k_penable),
		.pwrite  (m68k_pwrite),
		.paddr   (m68k_paddr),
		.pwdata  (m68k_pwdata),
		.pstrb   (m68k_pstrb),
		.prdata  (m68k_prdata),
		.pready  (m68k_pready),
		.mb      (mb_m68k)
	);

	z80_apb_port z80_port (
		.MCLK    (MCLK),
		.reset   (reset),
		.psel    (z80_psel),
		.penable (z80_penable),
		.pwrite  (z80_pwrite),
		.paddr   (z80_paddr),
		.pwdata  (z80_pwdata),
		.prdata  (z80_prdata),
		.pready  (z80_pready),
		.mb      (mb_z80),
		.zb      (zb_z80)
	);

	mbus_controller #(
		.WRAM_AW (WRAM_AW)
	) mbus_ctrl (
		.MCLK         (MCLK),
		.reset        (reset),
		.m68k         (mb_m68k),
		.z80          (mb_z80),
		.zb           (zb_main),
		.wram_addr    (wram_addr),
		.wram_wdata   (wram_wdata),
		.wram_we      (wram_we),
		.wram_rdata   (wram_rdata),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n)
	);

	zbus_controller #(
		.ZRAM_AW (ZRAM_AW)
	) zbus_ctrl (
		.MCLK         (MCLK),
		.reset        (reset),
		.main         (zb_main),
		.z80          (zb_z80),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n)
	);

	// 64 KB work RAM as two byte lanes
	byte_lane_ram #(
		.ADDR_W (WRAM_AW),
		.LANES  (2)
	) wram (
		.MCLK   (MCLK),
		.addr   (wram_addr),
		.wdata  (wram_wdata),
		.we     (wram_we),
		.rdata  (wram_rdata)
	);

endmodule

`default_nettype wire

//--- hw/m68k_apb_port.sv
// ------------------------------------------------
// 68000 side APB slave
// Turns each APB access into a main-bus request
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module m68k_apb_port (
	input  wire                                MCLK,
	input  wire                                reset,
	input  wire                                psel,
	input  wire                                penable,
	input  wire                                pwrite,
	input  wire  [genesis_bus_pkg::M68K_AW:0]  paddr,
	input  wire  [genesis_bus_pkg::M68K_DW-1:0] pwdata,
	input  wire  [1:0]                         pstrb,
	output logic [genesis_bus_pkg::M68K_DW-1:0] prdata,
	output logic                               pready,
	mbus_if.master                             mb
);

	// Request lives from the first access cycle until pready
	assign mb.req   = psel & penable & ~pready;
	assign mb.addr  = paddr[genesis_bus_pkg::M68K_AW:1];
	assign mb.wdata = pwdata;
	assign mb.we    = pwrite;
	// Reads always fetch the whole word
	assign mb.be    = pwrite ? pstrb : 2'b11;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			pready <= 1'b0;
		end else begin
			pready <= mb.ack;
		end
	end

	always_ff @(posedge MCLK) begin
		if (mb.ack) begin
			prdata <= mb.rdata;
		end
	end

	// APB master must hold the transfer while we wait
	assert property (@(posedge MCLK) disable iff (reset)
		psel && penable && !pready |=> psel && penable && $stable(paddr)
			&& $stable(pwrite) && $stable(pwdata) && $stable(pstrb));

endmodule

`default_nettype wire

//--- hw/mbus_controller.sv
// ------------------------------------------------
// Main-bus controller
// Arbitrates 68000 and Z80 window requests, decodes
// work RAM, Z80 space and the control registers
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mbus_controller #(
	parameter int WRAM_AW = 15
) (
	input  wire                                 MCLK,
	input  wire                                 reset,
	mbus_if.slave                               m68k,
	mbus_if.slave                               z80,
	zbus_if.requester                           zb,
	output logic [WRAM_AW-1:0]                  wram_addr,
	output logic [genesis_bus_pkg::M68K_DW-1:0] wram_wdata,
	output logic [1:0]                          wram_we,
	input  wire  [genesis_bus_pkg::M68K_DW-1:0] wram_rdata,
	output logic                                z80_busreq_n,
	output logic                                z80_reset_n
);

	localparam logic [2:0] S_IDLE      = 3'd0;
	localparam logic [2:0] S_SELECT    = 3'd1;
	localparam logic [2:0] S_RAM_WAIT  = 3'd2;
	localparam logic [2:0] S_ZBUS_WAIT = 3'd3;
	localparam logic [2:0] S_FINISH    = 3'd4;

	localparam logic SRC_M68K = 1'b0;
	localparam logic SRC_Z80  = 1'b1;

	logic [2:0]                          state;
	logic                                src;
	logic [genesis_bus_pkg::M68K_AW-1:0] a;
	logic [genesis_bus_pkg::M68K_DW-1:0] wd;
	logic [genesis_bus_pkg::M68K_DW-1:0] data;
	logic [genesis_bus_pkg::M68K_DW-1:0] ctrl_word;
	logic                                we;
	logic [1:0]                          be;
	logic                                m68k_ack;
	logic                                z80_ack;
	logic                                zb_req;
	logic                                take_m68k;
	logic                                take_z80;
	logic                                wram_hit;
	logic                                zwin_hit;
	logic                                ctrl_hit;
	logic [3:0]                          ctrl_sel;

	// A master just acked is still holding req for one cycle
	assign take_m68k = state == S_IDLE && m68k.req && !m68k_ack;
	assign take_z80  = state == S_IDLE && !take_m68k && z80.req && !z80_ack;

	// ------------------------------------------------
	// Decode of the latched word address
	// ------------------------------------------------
	assign wram_hit = a[22:20] == genesis_bus_pkg::WRAM_TOP;
	assign zwin_hit = a[22:15] == genesis_bus_pkg::ZWIN_PAGE;
	assign ctrl_hit = a[22:11] == genesis_bus_pkg::CTRL_PAGE;
	assign ctrl_sel = a[10:7];

	always_comb begin
		ctrl_word = genesis_bus_pkg::OPEN_WORD;
		if (ctrl_sel == genesis_bus_pkg::CTRL_BUSREQ_SEL) begin
			ctrl_word[genesis_bus_pkg::CTRL_BIT] = z80_busreq_n;
		end else if (ctrl_sel == genesis_bus_pkg::CTRL_RESET_SEL) begin
			ctrl_word[genesis_bus_pkg::CTRL_BIT] = z80_reset_n;
		end
	end

	assign wram_addr  = a[WRAM_AW-1:0];
	assign wram_wdata = wd;
	assign wram_we    = (state == S_SELECT && wram_hit && we) ? be : 2'b00;

	// Byte access into Z80 space
	// Upper lane is the even address
	assign zb.req   = zb_req;
	assign zb.addr  = {a[13:0], ~be[1]};
	assign zb.wdata = be[1] ? wd[15:8] : wd[7:0];
	assign zb.we    = we;

	assign m68k.rdata = data;
	assign m68k.ack   = m68k_ack;
	assign z80.rdata  = data;
	assign z80.ack    = z80_ack;

	// Request capture and read data
	always_ff @(posedge MCLK) begin
		if (take_m68k) begin
			src <= SRC_M68K;
			a   <= m68k.addr;
			wd  <= m68k.wdata;
			we  <= m68k.we;
			be  <= m68k.be;
		end else if (take_z80) begin
			src <= SRC_Z80;
			a   <= z80.addr;
			wd  <= z80.wdata;
			we  <= z80.we;
			be  <= z80.be;
		end
		case (state)
			S_SELECT:    data <= ctrl_hit ? ctrl_word : genesis_bus_pkg::OPEN_WORD;
			S_RAM_WAIT:  data <= wram_rdata;
			S_ZBUS_WAIT: data <= {zb.rdata, zb.rdata};
			default:     data <= data;
		endcase
	end

	// ------------------------------------------------
	// Transfer FSM and control registers
	// ------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state        <= S_IDLE;
			m68k_ack     <= 1'b0;
			z80_ack      <= 1'b0;
			zb_req       <= 1'b0;
			z80_busreq_n <= 1'b1;
			z80_reset_n  <= 1'b0;
		end else begin
			m68k_ack <= 1'b0;
			z80_ack  <= 1'b0;
			case (state)
				S_IDLE: begin
					if (take_m68k || take_z80) begin
						state <= S_SELECT;
					end
				end
				S_SELECT: begin
					if (wram_hit) begin
						state <= S_RAM_WAIT;
					end else if (zwin_hit) begin
						zb_req <= 1'b1;
						state  <= S_ZBUS_WAIT;
					end else begin
						// Only the upper lane reaches bit 8
						if (ctrl_hit && we && be[1]) begin
							if (ctrl_sel == genesis_bus_pkg::CTRL_BUSREQ_SEL) begin
								z80_busreq_n <= ~wd[genesis_bus_pkg::CTRL_BIT];
							end
							if (ctrl_sel == genesis_bus_pkg::CTRL_RESET_SEL) begin
								z80_reset_n <= wd[genesis_bus_pkg::CTRL_BIT];
							end
						end
						state <= S_FINISH;
					end
				end
				S_RAM_WAIT: begin
					state <= S_FINISH;
				end
				S_ZBUS_WAIT: begin
					if (zb.ack) begin
						zb_req <= 1'b0;
						state  <= S_FINISH;
					end
				end
				S_FINISH: begin
					m68k_ack <= src == SRC_M68K;
					z80_ack  <= src == SRC_Z80;
					state    <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Acks answer only a live request
	assert property (@(posedge MCLK) disable iff (reset) m68k.ack |-> m68k.req);
	assert property (@(posedge MCLK) disable iff (reset) z80.ack |-> z80.req);

endmodule

`default_nettype wire

//--- hw/mbus_if.sv
// ------------------------------------------------
// Main-bus request channel
// One master port to the main-bus controller
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface mbus_if;

	logic                                req;
	logic [genesis_bus_pkg::M68K_AW-1:0] addr;
	logic [genesis_bus_pkg::M68K_DW-1:0] wdata;
	logic                                we;
	// Bit 1 is the upper (even) byte
	logic [1:0]                          be;
	logic [genesis_bus_pkg::M68K_DW-1:0] rdata;
	logic                                ack;

	// Request held until the one-cycle ack
	modport master (
		output req, addr, wdata, we, be,
		input  rdata, ack
	);

	modport slave (
		input  req, addr, wdata, we, be,
		output rdata, ack
	);

endinterface

`default_nettype wire

//--- hw/z80_apb_port.sv
// ------------------------------------------------
// Z80 side APB slave
// Local decode, bank register and the 8000-FFFF
// window into main-bus space
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module z80_apb_port (
	input  wire                                MCLK,
	input  wire                                reset,
	input  wire                                psel,
	input  wire                                penable,
	input  wire                                pwrite,
	input  wire  [genesis_bus_pkg::Z80_AW-1:0] paddr,
	input  wire  [genesis_bus_pkg::Z80_DW-1:0] pwdata,
	output logic [genesis_bus_pkg::Z80_DW-1:0] prdata,
	output logic                               pready,
	mbus_if.master                             mb,
	zbus_if.requester                          zb
);

	logic [6:0]                         page;
	logic [genesis_bus_pkg::BANK_W-1:0] bank;
	logic                               access;
	logic                               win_sel;
	logic                               zb_sel;
	logic                               local_go;
	logic [genesis_bus_pkg::Z80_DW-1:0] win_byte;

	assign access  = psel & penable & ~pready;
	assign page    = paddr[14:8];
	assign win_sel = paddr[15];
	// Pages below 7F except the bank register page
	assign zb_sel  = !paddr[15] && (page < genesis_bus_pkg::Z80_LOCAL_LIMIT)
		&& (page != genesis_bus_pkg::Z80_BANK_PAGE);
	// Bank register and page 7F answer here in one cycle
	assign local_go = access & ~win_sel & ~zb_sel;

	// ------------------------------------------------
	// Window into main-bus space
	// ------------------------------------------------
	assign mb.req   = access & win_sel;
	assign mb.addr  = {bank, paddr[14:1]};
	assign mb.wdata = {pwdata, pwdata};
	assign mb.we    = pwrite;
	// Even byte sits on the upper lane
	assign mb.be    = paddr[0] ? 2'b01 : 2'b10;
	assign win_byte = paddr[0] ? mb.rdata[7:0] : mb.rdata[15:8];

	// Z80 RAM side
	assign zb.req   = access & zb_sel;
	assign zb.addr  = paddr[14:0];
	assign zb.wdata = pwdata;
	assign zb.we    = pwrite;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			pready <= 1'b0;
			bank   <= '0;
		end else begin
			pready <= mb.ack | zb.ack | local_go;
			// One address bit per write, shifted in from the top
			if (local_go && pwrite && page == genesis_bus_pkg::Z80_BANK_PAGE) begin
				bank <= {pwdata[0], bank[genesis_bus_pkg::BANK_W-1:1]};
			end
		end
	end

	always_ff @(posedge MCLK) begin
		if (mb.ack) begin
			prdata <= win_byte;
		end else if (zb.ack) begin
			prdata <= zb.rdata;
		end else if (local_go) begin
			prdata <= genesis_bus_pkg::OPEN_BYTE;
		end
	end

endmodule

`default_nettype wire

//--- hw/zbus_controller.sv
// ------------------------------------------------
// Z80-bus controller
// Shares the 8 KB Z80 RAM between the main bus
// and the Z80, gated by bus grant and Z80 reset
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module zbus_controller #(
	parameter int ZRAM_AW = 13
) (
	input  wire        MCLK,
	input  wire        reset,
	zbus_if.controller main,
	zbus_if.controller z80,
	input  wire        z80_busreq_n,
	input  wire        z80_reset_n
);

	localparam logic [1:0] S_IDLE   = 2'd0;
	localparam logic [1:0] S_READ   = 2'd1;
	localparam logic [1:0] S_FINISH = 2'd2;

	logic [1:0]                          state;
	logic                                src_main;
	logic [genesis_bus_pkg::ZBUS_AW-1:0] za;
	logic [genesis_bus_pkg::Z80_DW-1:0]  zd;
	logic                                zw;
	logic [genesis_bus_pkg::Z80_DW-1:0]  zram_q;
	logic [genesis_bus_pkg::Z80_DW-1:0]  sel_data;
	logic [genesis_bus_pkg::Z80_DW-1:0]  rdata_q;
	logic                                main_ack;
	logic                                z80_ack;
	logic                                bus_free;
	logic                                take_main;
	logic                                take_z80;
	logic                                zram_hit;
	logic                                zram_we;

	// Main bus owns Z80 RAM only with bus granted and Z80 running
	assign bus_free  = ~z80_busreq_n & z80_reset_n;
	assign take_main = state == S_IDLE && main.req && !main_ack;
	assign take_z80  = state == S_IDLE && !take_main && z80.req && !z80_ack;

	// RAM mirrored over 0000-3FFF
	// Upper half reads as open bus
	assign zram_hit = ~za[14];
	assign zram_we  = state == S_READ && zw && zram_hit && (!src_main || bus_free);
	assign sel_data = zram_hit ? zram_q : genesis_bus_pkg::OPEN_BYTE;

	byte_lane_ram #(
		.ADDR_W (ZRAM_AW),
		.LANES  (1)
	) zram (
		.MCLK   (MCLK),
		.addr   (za[ZRAM_AW-1:0]),
		.wdata  (zd),
		.we     (zram_we),
		.rdata  (zram_q)
	);

	assign main.rdata = rdata_q;
	assign main.ack   = main_ack;
	assign z80.rdata  = rdata_q;
	assign z80.ack    = z80_ack;

	always_ff @(posedge MCLK) begin
		if (take_main) begin
			src_main <= 1'b1;
			za       <= main.addr;
			zd       <= main.wdata;
			zw       <= main.we;
		end else if (take_z80) begin
			src_main <= 1'b0;
			za       <= z80.addr;
			zd       <= z80.wdata;
			zw       <= z80.we;
		end
		if (state == S_FINISH) begin
			rdata_q <= (src_main && !bus_free) ? genesis_bus_pkg::OPEN_BYTE : sel_data;
		end
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state    <= S_IDLE;
			main_ack <= 1'b0;
			z80_ack  <= 1'b0;
		end else begin
			main_ack <= 1'b0;
			z80_ack  <= 1'b0;
			case (state)
				S_IDLE: begin
					if (take_main || take_z80) begin
						state <= S_READ;
					end
				end
				S_READ: begin
					state <= S_FINISH;
				end
				S_FINISH: begin
					main_ack <= src_main;
					z80_ack  <= ~src_main;
					state    <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Each requester still holds its request when acked
	assert property (@(posedge MCLK) disable iff (reset) main.ack |-> main.req);
	assert property (@(posedge MCLK) disable iff (reset) z80.ack |-> z80.req);

endmodule

`default_nettype wire

//--- hw/zbus_if.sv
// ------------------------------------------------
// Z80-bus request channel
// Byte access to the Z80-bus controller
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface zbus_if;

	logic                                req;
	logic [genesis_bus_pkg::ZBUS_AW-1:0] addr;
	logic [genesis_bus_pkg::Z80_DW-1:0]  wdata;
	logic                                we;
	logic [genesis_bus_pkg::Z80_DW-1:0]  rdata;
	logic                                ack;

	modport requester (
		output req, addr, wdata, we,
		input  rdata, ack
	);

	modport controller (
		input  req, addr, wdata, we,
		output rdata, ack
	);

endinterface

`default_nettype wire

//--- list.f
hw/genesis_bus_pkg.sv
hw/mbus_if.sv
hw/zbus_if.sv
hw/byte_lane_ram.sv
hw/m68k_apb_port.sv
hw/z80_apb_port.sv
hw/mbus_controller.sv
hw/zbus_controller.sv
hw/genesis_bus_top.sv
verification/tb_genesis_bus.sv

//--- verification/tb_genesis_bus.sv
// ------------------------------------------------
// Genesis bus fabric testbench
// Drives both APB ports through directed tests of
// work RAM, Z80 RAM gating, banking and open bus
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_genesis_bus;

	localparam int XFER_COUNT      = 52;
	localparam int XFER_MAX_CYCLES = 20;
	localparam int WATCHDOG_CYCLES = XFER_COUNT * XFER_MAX_CYCLES + 100;

	logic        MCLK;
	logic        reset;
	logic        m68k_psel;
	logic        m68k_penable;
	logic        m68k_pwrite;
	logic [23:0] m68k_paddr;
	logic [15:0] m68k_pwdata;
	logic [1:0]  m68k_pstrb;
	wire  [15:0] m68k_prdata;
	wire         m68k_pready;
	logic        z80_psel;
	logic        z80_penable;
	logic        z80_pwrite;
	logic [15:0] z80_paddr;
	logic [7:0]  z80_pwdata;
	wire  [7:0]  z80_prdata;
	wire         z80_pready;
	wire         z80_busreq_n;
	wire         z80_reset_n;

	int errors;
	int checks;
	int tests;
	int tests_with_errors;

	genesis_bus_top dut0 (
		.MCLK         (MCLK),
		.reset        (reset),
		.m68k_psel    (m68k_psel),
		.m68k_penable (m68k_penable),
		.m68k_pwrite  (m68k_pwrite),
		.m68k_paddr   (m68k_paddr),
		.m68k_pwdata  (m68k_pwdata),
		.m68k_pstrb   (m68k_pstrb),
		.m68k_prdata  (m68k_prdata),
		.m68k_pready  (m68k_pready),
		.z80_psel     (z80_psel),
		.z80_penable  (z80_penable),
		.z80_pwrite   (z80_pwrite),
		.z80_paddr    (z80_paddr),
		.z80_pwdata   (z80_pwdata),
		.z80_prdata   (z80_prdata),
		.z80_pready   (z80_pready),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n)
	);

	initial MCLK = 1'b0;
	always #20 MCLK = ~MCLK;

	// ------------------------------------------------
	// Checking and reporting
	// ------------------------------------------------
	task automatic compare_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests++;
		if (errors == start_errors) begin
			$display("%s: ok", name);
		end else begin
			tests_with_errors++;
			$display("%s: %0d errors", name, errors - start_errors);
		end
	endtask

	// ------------------------------------------------
	// APB drivers, entered 2 ns after a rising edge
	// ------------------------------------------------
	task automatic apb68_transfer(input logic write, input logic [23:0] addr,
		input logic [15:0] wdata, input logic [1:0] strb, output logic [15:0] rdata);
		int cycles;
		m68k_psel    = 1'b1;
		m68k_penable = 1'b0;
		m68k_pwrite  = write;
		m68k_paddr   = addr;
		m68k_pwdata  = wdata;
		m68k_pstrb   = strb;
		@(posedge MCLK);
		#2;
		m68k_penable = 1'b1;
		cycles = 0;
		// pready is looked at on the falling edge where it is stable
		do begin
			@(negedge MCLK);
			cycles++;
		end while (!m68k_pready && cycles < XFER_MAX_CYCLES);
		if (!m68k_pready) begin
			$display("68000 port gave no pready within %0d cycles at address %h",
				XFER_MAX_CYCLES, addr);
			errors++;
		end
		rdata = m68k_prdata;
		@(posedge MCLK);
		#2;
		m68k_psel    = 1'b0;
		m68k_penable = 1'b0;
		m68k_pwrite  = 1'b0;
	endtask

	task automatic apb68_write(input logic [23:0] addr, input logic [15:0] wdata,
		input logic [1:0] strb);
		logic [15:0] unused_rdata;
		apb68_transfer(1'b1, addr, wdata, strb, unused_rdata);
	endtask

	task automatic apb68_read(input logic [23:0] addr, output logic [15:0] rdata);
		apb68_transfer(1'b0, addr, 16'h0000, 2'b11, rdata);
	endtask

	task automatic z80_transfer(input logic write, input logic [15:0] addr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		int cycles;
		z80_psel    = 1'b1;
		z80_penable = 1'b0;
		z80_pwrite  = write;
		z80_paddr   = addr;
		z80_pwdata  = wdata;
		@(posedge MCLK);
		#2;
		z80_penable = 1'b1;
		cycles = 0;
		do begin
			@(negedge MCLK);
			cycles++;
		end while (!z80_pready && cycles < XFER_MAX_CYCLES);
		if (!z80_pready) begin
			$display("Z80 port gave no pready within %0d cycles at address %h",
				XFER_MAX_CYCLES, addr);
			errors++;
		end
		rdata = z80_prdata;
		@(posedge MCLK);
		#2;
		z80_psel    = 1'b0;
		z80_penable = 1'b0;
		z80_pwrite  = 1'b0;
	endtask

	task automatic z80_write(input logic [15:0] addr, input logic [7:0] wdata);
		logic [7:0] unused_rdata;
		z80_transfer(1'b1, addr, wdata, unused_rdata);
	endtask

	task automatic z80_read(input logic [15:0] addr, output logic [7:0] rdata);
		z80_transfer(1'b0, addr, 8'h00, rdata);
	endtask

	// ------------------------------------------------
	// Directed tests
	// ------------------------------------------------
	task automatic reset_state();
		int start_errors;
		logic [15:0] r16;
		start_errors = errors;
		compare_value("m68k_pready", {15'h0, m68k_pready}, 16'h0000);
		compare_value("z80_pready", {15'h0, z80_pready}, 16'h0000);
		compare_value("z80_busreq_n", {15'h0, z80_busreq_n}, 16'h0001);
		compare_value("z80_reset_n", {15'h0, z80_reset_n}, 16'h0000);
		apb68_read(24'hA11100, r16);
		compare_value("m68k_prdata", r16, 16'hFFFF);
		// Bit 8 follows reset_n, still low
		apb68_read(24'hA11200, r16);
		compare_value("m68k_prdata", r16, 16'hFEFF);
		report_test("reset_state", start_errors);
	endtask

	task automatic wram_lanes();
		int start_errors;
		logic [15:0] w1;
		logic [15:0] w2;
		logic [15:0] r16;
		start_errors = errors;
		w1 = 16'($urandom);
		w2 = 16'($urandom);
		apb68_write(24'hE01234, w1, 2'b11);
		apb68_write(24'hE01234, w2, 2'b10);
		apb68_read(24'hE01234, r16);
		compare_value("m68k_prdata", r16, {w2[15:8], w1[7:0]});
		apb68_read(24'hFF1234, r16);
		compare_value("m68k_prdata", r16, {w2[15:8], w1[7:0]});
		// Same thing entered through the mirror, lower lane only
		w1 = 16'($urandom);
		w2 = 16'($urandom);
		apb68_write(24'hFF0100, w1, 2'b11);
		apb68_write(24'hFF0100, w2, 2'b01);
		apb68_read(24'hE00100, r16);
		compare_value("m68k_prdata", r16, {w1[15:8], w2[7:0]});
		report_test("wram_lanes", start_errors);
	endtask

	task automatic zbus_gating();
		int start_errors;
		logic [15:0] d;
		logic [15:0] r16;
		logic [7:0]  r8;
		start_errors = errors;
		d = 16'($urandom);
		z80_write(16'h0010, 8'h5A);
		// Bus not granted and Z80 in reset
		apb68_write(24'hA00010, ~d, 2'b11);
		apb68_read(24'hA00010, r16);
		compare_value("m68k_prdata", r16, 16'hFFFF);
		z80_read(16'h0010, r8);
		compare_value("z80_prdata", {8'h00, r8}, 16'h005A);
		apb68_write(24'hA11100, 16'h0100, 2'b11);
		apb68_write(24'hA11200, 16'h0100, 2'b11);
		compare_value("z80_busreq_n", {15'h0, z80_busreq_n}, 16'h0000);
		compare_value("z80_reset_n", {15'h0, z80_reset_n}, 16'h0001);
		apb68_read(24'hA11100, r16);
		compare_value("m68k_prdata", r16, 16'hFEFF);
		apb68_read(24'hA11200, r16);
		compare_value("m68k_prdata", r16, 16'hFFFF);
		// Granted now, upper lane is the even Z80 address
		apb68_write(24'hA00010, d, 2'b10);
		z80_read(16'h0010, r8);
		compare_value("z80_prdata", {8'h00, r8}, {8'h00, d[15:8]});
		z80_read(16'h2010, r8);
		compare_value("z80_prdata", {8'h00, r8}, {8'h00, d[15:8]});
		apb68_read(24'hA00010, r16);
		compare_value("m68k_prdata", r16, {d[15:8], d[15:8]});
		apb68_write(24'hA00010, ~d, 2'b01);
		z80_read(16'h0011, r8);
		compare_value("z80_prdata", {8'h00, r8}, {8'h00, ~d[7:0]});
		report_test("zbus_gating", start_errors);
	endtask

	task automatic bank_window();
		int start_errors;
		logic [8:0]  bank_val;
		logic [15:0] w1;
		logic [15:0] w2;
		logic [15:0] r16;
		logic [7:0]  r8;
		logic [7:0]  b;
		start_errors = errors;
		// Window base E18000 is byte address bits 23:15
		bank_val = 9'h1C3;
		w1 = 16'($urandom);
		w2 = 16'($urandom);
		b  = 8'($urandom);
		for (int i = 0; i < 9; i++) begin
			z80_write(16'h6000, {7'h00, bank_val[i]});
		end
		apb68_write(24'hE18246, w1, 2'b11);
		z80_read(16'h8246, r8);
		compare_value("z80_prdata", {8'h00, r8}, {8'h00, w1[15:8]});
		z80_read(16'h8247, r8);
		compare_value("z80_prdata", {8'h00, r8}, {8'h00, w1[7:0]});
		// Odd Z80 byte lands on the lower lane only
		apb68_write(24'hE18248, w2, 2'b11);
		z80_write(16'h8249, b);
		apb68_read(24'hE18248, r16);
		compare_value("m68k_prdata", r16, {w2[15:8], b});
		report_test("bank_window", start_errors);
	endtask

	task automatic open_bus();
		int start_errors;
		logic [15:0] r16;
		logic [7:0]  r8;
		start_errors = errors;
		apb68_read(24'h400000, r16);
		compare_value("m68k_prdata", r16, 16'hFFFF);
		z80_read(16'h4000, r8);
		compare_value("z80_prdata", {8'h00, r8}, 16'h00FF);
		z80_read(16'h7F00, r8);
		compare_value("z80_prdata", {8'h00, r8}, 16'h00FF);
		z80_read(16'h6000, r8);
		compare_value("z80_prdata", {8'h00, r8}, 16'h00FF);
		report_test("open_bus", start_errors);
	endtask

	task automatic concurrent();
		int start_errors;
		logic [15:0] w;
		logic [15:0] d;
		logic [15:0] r16;
		logic [7:0]  b1;
		logic [7:0]  b2;
		logic [7:0]  r8;
		start_errors = errors;
		w  = 16'($urandom);
		d  = 16'($urandom);
		b1 = 8'($urandom);
		b2 = 8'($urandom);
		fork
			apb68_write(24'hE02000, w, 2'b11);
			z80_write(16'h0100, b1);
		join
		fork
			apb68_read(24'hE02000, r16);
			z80_read(16'h0100, r8);
		join
		compare_value("m68k_prdata", r16, w);
		compare_value("z80_prdata", {8'h00, r8}, {8'h00, b1});
		// Both sides contend for the Z80 RAM
		fork
			apb68_write(24'hA00030, d, 2'b10);
			z80_write(16'h0031, b2);
		join
		fork
			apb68_read(24'hA00030, r16);
			z80_read(16'h0031, r8);
		join
		compare_value("m68k_prdata", r16, {d[15:8], d[15:8]});
		compare_value("z80_prdata", {8'h00, r8}, {8'h00, b2});
		report_test("concurrent", start_errors);
	endtask

	// ------------------------------------------------
	// Watchdog
	// ------------------------------------------------
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge MCLK);
		$display("Watchdog expired after %0d cycles, the run did not finish",
			WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		errors            = 0;
		checks            = 0;
		tests             = 0;
		tests_with_errors = 0;
		reset        = 1'b1;
		m68k_psel    = 1'b0;
		m68k_penable = 1'b0;
		m68k_pwrite  = 1'b0;
		m68k_paddr   = 24'h000000;
		m68k_pwdata  = 16'h0000;
		m68k_pstrb   = 2'b00;
		z80_psel     = 1'b0;
		z80_penable  = 1'b0;
		z80_pwrite   = 1'b0;
		z80_paddr    = 16'h0000;
		z80_pwdata   = 8'h00;
		void'($urandom(32'h5e78));
		repeat (4) @(posedge MCLK);
		#2;
		reset = 1'b0;

		reset_state();
		wram_lanes();
		zbus_gating();
		bank_window();
		open_bus();
		concurrent();

		$display("Tests: %0d, with errors: %0d, checks: %0d, check errors: %0d",
			tests, tests_with_errors, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
